/* source/axiwr_pkg.sv */
// Widths, AXI4 constants and channel payload structs for the posted write path.
// Modules import this package wherever they build or decode AW, W or B payloads.

package axiwr_pkg;

    ////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////

    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;

    ////////////////////////////////////////////////////////////////////
    // AXI4 encodings
    ////////////////////////////////////////////////////////////////////

    // 8 bytes per beat
    localparam logic [2:0] AXI_SIZE       = 3'd3;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    // Unprivileged, non-secure, data access
    localparam logic [2:0] AXI_PROT_DATA  = 3'b010;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    ////////////////////////////////////////////////////////////////////
    // Channel payloads
    ////////////////////////////////////////////////////////////////////

    // AW channel, 48 bits
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
        logic [2:0]        prot;
    } aw_req_t;

    // W channel, 73 bits
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_beat_t;

    // B channel
    typedef struct packed {
        logic [1:0] resp;
    } b_resp_t;

endpackage

/* source/wdata_fifo.sv */
// Write data FIFO between the request side and the AXI4 W channel.
// The memory read is registered and a second output register drives W.
// hold from the address holder blocks writes until an address is captured.

`timescale 1ns/1ns

module wdata_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  axiwr_pkg::w_beat_t in_beat,
    input  logic               hold,
    output logic               push,
    output logic               out_valid,
    input  logic               out_ready,
    output axiwr_pkg::w_beat_t out_beat
);
    import axiwr_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // Pointers carry one extra wrap bit
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;

    w_beat_t mem [FIFO_DEPTH];
    w_beat_t rd_data;
    logic    rd_valid;

    logic full;
    logic empty;
    logic write;
    logic read;
    logic load_out;

    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign in_ready = !full && !hold;
    assign write    = in_valid && in_ready;
    assign push     = write;

    // Output stage takes a new beat when empty or when W is accepted
    assign load_out = out_ready || !out_valid;
    assign read     = !empty && (load_out || !rd_valid);

    ////////////////////////////////////////////////////////////////////
    // Pointers and valid flags
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            rd_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (load_out || !rd_valid) begin
                rd_valid <= !empty;
            end
            if (load_out) begin
                out_valid <= rd_valid;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Storage and data path
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr[PTR_W-1:0]] <= in_beat;
        end
        if (read) begin
            rd_data <= mem[rd_ptr[PTR_W-1:0]];
        end
        if (load_out) begin
            out_beat <= rd_data;
        end
    end

endmodule

/* source/aw_hold.sv */
// Holds one write address until its data beats sit in the write data FIFO.
// Counts FIFO push pulses against len; a burst deeper than the FIFO is
// released once the FIFO fills so the W channel can start draining it.

`timescale 1ns/1ns

module aw_hold #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  axiwr_pkg::aw_req_t in_aw,
    input  logic               push,
    output logic               hold,
    output logic               aw_valid,
    input  logic               aw_ready,
    output axiwr_pkg::aw_req_t aw
);
    import axiwr_pkg::*;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_FILL  = 2'd1;
    localparam logic [1:0] ST_DRAIN = 2'd2;

    localparam logic [8:0] DEPTH_CNT = 9'(FIFO_DEPTH);

    logic [1:0] state;
    logic [1:0] state_next;
    logic [8:0] count;
    logic [8:0] count_next;
    logic       hold_next;
    logic       in_ready_next;
    logic       aw_valid_next;
    aw_req_t    aw_next;

    always_comb begin
        state_next    = state;
        count_next    = count;
        hold_next     = hold;
        aw_next       = aw;
        aw_valid_next = aw_valid && !aw_ready;
        in_ready_next = 1'b0;

        case (state)
            ST_IDLE: begin
                hold_next = 1'b1;
                // Only take a new address once AW output has gone idle
                in_ready_next = !aw_valid_next;
                if (in_valid && in_ready) begin
                    aw_next       = in_aw;
                    count_next    = '0;
                    hold_next     = 1'b0;
                    in_ready_next = 1'b0;
                    state_next    = ST_FILL;
                end
            end
            ST_FILL: begin
                if (push) begin
                    count_next = count + 9'd1;
                    if (count == {1'b0, aw.len}) begin
                        // Whole burst stored
                        aw_valid_next = 1'b1;
                        hold_next     = 1'b1;
                        state_next    = ST_IDLE;
                    end else if (count_next == DEPTH_CNT) begin
                        // FIFO full, let W drain the rest
                        aw_valid_next = 1'b1;
                        state_next    = ST_DRAIN;
                    end
                end
            end
            ST_DRAIN: begin
                if (push) begin
                    count_next = count + 9'd1;
                    if (count == {1'b0, aw.len}) begin
                        hold_next  = 1'b1;
                        state_next = ST_IDLE;
                    end
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            count    <= '0;
            hold     <= 1'b1;
            in_ready <= 1'b0;
            aw_valid <= 1'b0;
        end else begin
            state    <= state_next;
            count    <= count_next;
            hold     <= hold_next;
            in_ready <= in_ready_next;
            aw_valid <= aw_valid_next;
        end
        aw <= aw_next;
    end

endmodule

/* source/axiwr_master.sv */
// AXI4 write master built from the address holder and the write data FIFO.
// AW is released only after its data is stored; B passes straight through.

`timescale 1ns/1ns

module axiwr_master #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic               clk,
    input  logic               rst,
    // Request side
    input  logic               s_aw_valid,
    output logic               s_aw_ready,
    input  axiwr_pkg::aw_req_t s_aw,
    input  logic               s_w_valid,
    output logic               s_w_ready,
    input  axiwr_pkg::w_beat_t s_w,
    output logic               s_b_valid,
    input  logic               s_b_ready,
    output axiwr_pkg::b_resp_t s_b,
    // AXI4 write channels
    output axiwr_pkg::aw_req_t m_axi_aw,
    output logic               m_axi_awvalid,
    input  logic               m_axi_awready,
    output axiwr_pkg::w_beat_t m_axi_w,
    output logic               m_axi_wvalid,
    input  logic               m_axi_wready,
    input  axiwr_pkg::b_resp_t m_axi_b,
    input  logic               m_axi_bvalid,
    output logic               m_axi_bready
);

    logic hold;
    logic push;

    aw_hold #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_aw_hold (
        .clk      (clk),
        .rst      (rst),
        .in_valid (s_aw_valid),
        .in_ready (s_aw_ready),
        .in_aw    (s_aw),
        .push     (push),
        .hold     (hold),
        .aw_valid (m_axi_awvalid),
        .aw_ready (m_axi_awready),
        .aw       (m_axi_aw)
    );

    wdata_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_wdata_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (s_w_valid),
        .in_ready  (s_w_ready),
        .in_beat   (s_w),
        .hold      (hold),
        .push      (push),
        .out_valid (m_axi_wvalid),
        .out_ready (m_axi_wready),
        .out_beat  (m_axi_w)
    );

    // Responses come back in order, nothing to track
    assign s_b          = m_axi_b;
    assign s_b_valid    = m_axi_bvalid;
    assign m_axi_bready = s_b_ready;

endmodule

/* source/wr_req_tracker.sv */
// Turns single-beat client write strobes into an AW item followed by a W beat.
// Counts requests still waiting for B and responses that were not OKAY.

`timescale 1ns/1ns

module wr_req_tracker (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_strobe,
    input  logic [axiwr_pkg::ADDR_W-1:0] req_addr,
    input  logic [axiwr_pkg::DATA_W-1:0] req_data,
    input  logic [axiwr_pkg::STRB_W-1:0] req_strb,
    output logic                         busy,
    output logic                         done,
    output logic [15:0]                  err_count,
    output logic [7:0]                   outstanding,
    output logic                         aw_valid,
    input  logic                         aw_ready,
    output axiwr_pkg::aw_req_t           aw,
    output logic                         w_valid,
    input  logic                         w_ready,
    output axiwr_pkg::w_beat_t           w,
    input  logic                         b_valid,
    output logic                         b_ready,
    input  axiwr_pkg::b_resp_t           b
);
    import axiwr_pkg::*;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_AW   = 2'd1;
    localparam logic [1:0] ST_W    = 2'd2;

    logic [1:0]        state;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] data_q;
    logic [STRB_W-1:0] strb_q;
    logic              accept;
    logic              b_fire;

    assign accept  = req_strobe && (state == ST_IDLE);
    assign b_fire  = b_valid && b_ready;
    assign b_ready = 1'b1;

    assign busy     = (state != ST_IDLE);
    assign aw_valid = (state == ST_AW);
    assign w_valid  = (state == ST_W);

    // Single beat INCR bursts only
    assign aw = '{addr: addr_q, len: 8'd0, size: AXI_SIZE, burst: AXI_BURST_INCR,
                  prot: AXI_PROT_DATA};
    assign w  = '{data: data_q, strb: strb_q, last: 1'b1};

    // AW first, then W
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (accept) state <= ST_AW;
                ST_AW:   if (aw_ready) state <= ST_W;
                ST_W:    if (w_ready) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req_addr;
            data_q <= req_data;
            strb_q <= req_strb;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Completion counters
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            done        <= 1'b0;
            err_count   <= '0;
            outstanding <= '0;
        end else begin
            done <= b_fire;
            if (b_fire && (b.resp != RESP_OKAY)) begin
                err_count <= err_count + 16'd1;
            end
            // Accept and response in the same cycle cancel out
            case ({accept, b_fire})
                2'b10:   outstanding <= outstanding + 8'd1;
                2'b01:   outstanding <= outstanding - 8'd1;
                default: outstanding <= outstanding;
            endcase
        end
    end

endmodule

/* source/axiwr_top.sv */
// Posted write path top level, client strobe interface in and AXI4 write out.
// FIFO_DEPTH sets the write data buffer and must be a power of two.

`timescale 1ns/1ns

module axiwr_top #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    // Client
    input  logic                         req_strobe,
    input  logic [axiwr_pkg::ADDR_W-1:0] req_addr,
    input  logic [axiwr_pkg::DATA_W-1:0] req_data,
    input  logic [axiwr_pkg::STRB_W-1:0] req_strb,
    output logic                         busy,
    output logic                         done,
    output logic [15:0]                  err_count,
    output logic [7:0]                   outstanding,
    // AXI4 write channels
    output axiwr_pkg::aw_req_t           m_axi_aw,
    output logic                         m_axi_awvalid,
    input  logic                         m_axi_awready,
    output axiwr_pkg::w_beat_t           m_axi_w,
    output logic                         m_axi_wvalid,
    input  logic                         m_axi_wready,
    input  axiwr_pkg::b_resp_t           m_axi_b,
    input  logic                         m_axi_bvalid,
    output logic                         m_axi_bready
);
    import axiwr_pkg::*;

    logic    aw_valid;
    logic    aw_ready;
    aw_req_t aw;
    logic    w_valid;
    logic    w_ready;
    w_beat_t w;
    logic    b_valid;
    logic    b_ready;
    b_resp_t b;

    wr_req_tracker u_wr_req_tracker (
        .clk         (clk),
        .rst         (rst),
        .req_strobe  (req_strobe),
        .req_addr    (req_addr),
        .req_data    (req_data),
        .req_strb    (req_strb),
        .busy        (busy),
        .done        (done),
        .err_count   (err_count),
        .outstanding (outstanding),
        .aw_valid    (aw_valid),
        .aw_ready    (aw_ready),
        .aw          (aw),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .w           (w),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .b           (b)
    );

    axiwr_master #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_axiwr_master (
        .clk           (clk),
        .rst           (rst),
        .s_aw_valid    (aw_valid),
        .s_aw_ready    (aw_ready),
        .s_aw          (aw),
        .s_w_valid     (w_valid),
        .s_w_ready     (w_ready),
        .s_w           (w),
        .s_b_valid     (b_valid),
        .s_b_ready     (b_ready),
        .s_b           (b),
        .m_axi_aw      (m_axi_aw),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .m_axi_w       (m_axi_w),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wready  (m_axi_wready),
        .m_axi_b       (m_axi_b),
        .m_axi_bvalid  (m_axi_bvalid),
        .m_axi_bready  (m_axi_bready)
    );

endmodule

/* tests/axi_slave_model.sv */
// AXI4 write slave model with a word memory and random back-pressure.
// Addresses at or above ERR_BASE answer SLVERR and leave the memory untouched.
// Outputs change 2 ns after the rising edge; handshakes are taken at the edge.

`timescale 1ns/1ns

module axi_slave_model #(
    parameter logic [31:0] SEED     = 32'ha2438f19,
    parameter logic [31:0] ERR_BASE = 32'h0000_8000,
    parameter int          WORDS    = 8192
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall_en,
    input  axiwr_pkg::aw_req_t aw,
    input  logic               awvalid,
    output logic               awready,
    input  axiwr_pkg::w_beat_t w,
    input  logic               wvalid,
    output logic               wready,
    output axiwr_pkg::b_resp_t b,
    output logic               bvalid,
    input  logic               bready
);
    import axiwr_pkg::*;

    logic [DATA_W-1:0] mem [WORDS];
    logic [31:0]       lfsr_state = SEED;
    logic [ADDR_W-1:0] addr_q[$];
    w_beat_t           beat_q[$];
    logic [1:0]        resp_q[$];
    int                b_wait;

    // Galois LFSR, one step per bit drawn
    function automatic logic lfsr_step();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [7:0] draw_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_step()};
        end
        return v;
    endfunction

    initial begin
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        b       = '0;
        b_wait  = 0;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = {~32'(i), 32'(i) ^ 32'h5a5a_5a5a};
        end
    end

    always @(posedge clk) begin
        logic              in_reset;
        logic              stall;
        logic              drop_b;
        logic [ADDR_W-1:0] addr;
        w_beat_t           beat;
        int                idx;
        in_reset = rst;
        stall    = stall_en;
        drop_b   = bvalid && bready;
        if (in_reset) begin
            addr_q.delete();
            beat_q.delete();
            resp_q.delete();
        end else begin
            if (awvalid && awready) begin
                addr_q.push_back(aw.addr);
            end
            if (wvalid && wready) begin
                beat_q.push_back(w);
            end
            // Single beat bursts, so each address pairs with the next beat
            if (addr_q.size() > 0 && beat_q.size() > 0) begin
                addr = addr_q.pop_front();
                beat = beat_q.pop_front();
                idx  = int'(addr >> 3);
                if (addr >= ERR_BASE) begin
                    resp_q.push_back(RESP_SLVERR);
                end else begin
                    for (int i = 0; i < STRB_W; i++) begin
                        if (beat.strb[i]) begin
                            mem[idx][i*8 +: 8] = beat.data[i*8 +: 8];
                        end
                    end
                    resp_q.push_back(RESP_OKAY);
                end
            end
        end
        #2;
        if (in_reset) begin
            awready = 1'b0;
            wready  = 1'b0;
            bvalid  = 1'b0;
            b_wait  = 0;
        end else begin
            awready = stall ? lfsr_step() : 1'b1;
            wready  = stall ? lfsr_step() : 1'b1;
            if (drop_b) begin
                bvalid = 1'b0;
            end
            if (!bvalid && resp_q.size() > 0) begin
                if (b_wait > 0) begin
                    b_wait = b_wait - 1;
                end else begin
                    bvalid = 1'b1;
                    b.resp = resp_q.pop_front();
                    b_wait = stall ? int'(draw_bits(2)) : 0;
                end
            end
        end
    end

endmodule

/* tests/tb_axiwr_top.sv */
// Testbench for the posted write path. Client writes go through the DUT into
// a slave model with random stalls and are checked against a scoreboard.
// Protocol rules are watched by concurrent assertions for the whole run.

`timescale 1ns/1ns

module tb_axiwr_top;
    import axiwr_pkg::*;

    localparam int          FIFO_DEPTH     = 16;
    localparam int          WORDS          = 8192;
    localparam int          NUM_RANDOM     = 50;
    localparam int          NUM_ERR        = 8;
    localparam int          NUM_REQ        = 1 + NUM_RANDOM + NUM_ERR;
    localparam int          TIMEOUT_CYCLES = 200 * NUM_REQ + 100;
    localparam logic [31:0] ERR_BASE       = 32'h0000_8000;

    logic              clk;
    logic              rst;
    logic              req_strobe;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_data;
    logic [STRB_W-1:0] req_strb;
    logic              busy;
    logic              done;
    logic [15:0]       err_count;
    logic [7:0]        outstanding;
    logic              stall_en;

    aw_req_t m_axi_aw;
    logic    m_axi_awvalid;
    logic    m_axi_awready;
    w_beat_t m_axi_w;
    logic    m_axi_wvalid;
    logic    m_axi_wready;
    b_resp_t m_axi_b;
    logic    m_axi_bvalid;
    logic    m_axi_bready;

    logic [DATA_W-1:0] expect_mem [WORDS];
    logic [31:0]       lfsr_state = 32'ha2438f19;
    int errors      = 0;
    int checks      = 0;
    int tests_run   = 0;
    int stab_fail   = 0;
    int order_fail  = 0;
    int expect_done = 0;
    int expect_err  = 0;
    int done_count  = 0;
    int cycle_count = 0;
    int aw_hs       = 0;
    int w_hs        = 0;
    int push_count  = 0;

    axiwr_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_axiwr_top (
        .clk           (clk),
        .rst           (rst),
        .req_strobe    (req_strobe),
        .req_addr      (req_addr),
        .req_data      (req_data),
        .req_strb      (req_strb),
        .busy          (busy),
        .done          (done),
        .err_count     (err_count),
        .outstanding   (outstanding),
        .m_axi_aw      (m_axi_aw),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .m_axi_w       (m_axi_w),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wready  (m_axi_wready),
        .m_axi_b       (m_axi_b),
        .m_axi_bvalid  (m_axi_bvalid),
        .m_axi_bready  (m_axi_bready)
    );

    axi_slave_model #(
        .SEED     (32'ha2438f19),
        .ERR_BASE (ERR_BASE),
        .WORDS    (WORDS)
    ) u_slave (
        .clk      (clk),
        .rst      (rst),
        .stall_en (stall_en),
        .aw       (m_axi_aw),
        .awvalid  (m_axi_awvalid),
        .awready  (m_axi_awready),
        .w        (m_axi_w),
        .wvalid   (m_axi_wvalid),
        .wready   (m_axi_wready),
        .b        (m_axi_b),
        .bvalid   (m_axi_bvalid),
        .bready   (m_axi_bready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Handshake and completion counters
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (done) begin
            done_count <= done_count + 1;
        end
        if (m_axi_awvalid && m_axi_awready) begin
            aw_hs <= aw_hs + 1;
        end
        if (m_axi_wvalid && m_axi_wready) begin
            w_hs <= w_hs + 1;
        end
        if (u_axiwr_top.w_valid && u_axiwr_top.w_ready) begin
            push_count <= push_count + 1;
        end
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("run stopped: writes still pending after %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Protocol assertions
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst)
        (m_axi_awvalid && !m_axi_awready) |=> (m_axi_awvalid && $stable(m_axi_aw)))
    else begin
        stab_fail++;
        $display("error %0t: AW valid or payload changed while stalled", $time);
    end

    assert property (@(posedge clk) disable iff (rst)
        (m_axi_wvalid && !m_axi_wready) |=> (m_axi_wvalid && $stable(m_axi_w)))
    else begin
        stab_fail++;
        $display("error %0t: W valid or payload changed while stalled", $time);
    end

    assert property (@(posedge clk) disable iff (rst)
        m_axi_wvalid |-> m_axi_w.last)
    else begin
        stab_fail++;
        $display("error %0t: W beat without last", $time);
    end

    // Every AW is one 8 byte INCR beat with unprivileged non-secure data access
    assert property (@(posedge clk) disable iff (rst)
        m_axi_awvalid |-> (m_axi_aw.len == 8'd0 && m_axi_aw.size == 3'd3 &&
                           m_axi_aw.burst == 2'b01 && m_axi_aw.prot == 3'b010))
    else begin
        stab_fail++;
        $display("error %0t: AW len %0d size %0d burst %0d prot %0d, expected 0 3 1 2",
                 $time, m_axi_aw.len, m_axi_aw.size, m_axi_aw.burst, m_axi_aw.prot);
    end

    assert property (@(posedge clk) disable iff (rst)
        m_axi_bvalid |-> m_axi_bready)
    else begin
        stab_fail++;
        $display("error %0t: B response offered while bready is low", $time);
    end

    // Beats seen by the slave plus beats still buffered equal the pushes
    assert property (@(posedge clk) disable iff (rst) aw_hs <= push_count)
    else begin
        order_fail++;
        $display("error %0t: %0d AW handshakes ahead of %0d stored beats", $time, aw_hs,
                 push_count);
    end

    assert property (@(posedge clk) disable iff (rst) w_hs <= aw_hs + 1)
    else begin
        order_fail++;
        $display("error %0t: %0d W beats against %0d AW handshakes", $time, w_hs, aw_hs);
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic lfsr_step();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [63:0] random_word(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_step()};
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("error %0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic check_memory();
        checks++;
        for (int i = 0; i < WORDS; i++) begin
            assert (u_slave.mem[i] === expect_mem[i]) else begin
                errors++;
                $display("error %0t: word at %0h is %0h, expected %0h", $time, i * 8,
                         u_slave.mem[i], expect_mem[i]);
            end
        end
    endtask

    task automatic issue_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                               input logic [STRB_W-1:0] strb);
        int idx;
        idx = int'(addr >> 3);
        while (busy) begin
            @(posedge clk);
            #2;
        end
        req_strobe = 1'b1;
        req_addr   = addr;
        req_data   = data;
        req_strb   = strb;
        @(posedge clk);
        #2;
        req_strobe = 1'b0;
        expect_done++;
        if (addr >= ERR_BASE) begin
            expect_err++;
        end else begin
            for (int i = 0; i < STRB_W; i++) begin
                if (strb[i]) begin
                    expect_mem[idx][i*8 +: 8] = data[i*8 +: 8];
                end
            end
        end
    endtask

    task automatic wait_idle();
        while (busy || outstanding != 8'd0) begin
            @(posedge clk);
            #2;
        end
        // done trails the last response by one edge in the counter
        @(posedge clk);
        #2;
    endtask

    task automatic report_test(input string name, input int fails);
        tests_run++;
        if (fails == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, fails);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          mark;
        logic [63:0] rnd;
        logic [31:0] addr;
        rst        = 1'b1;
        req_strobe = 1'b0;
        req_addr   = '0;
        req_data   = '0;
        req_strb   = '0;
        stall_en   = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < WORDS; i++) begin
            expect_mem[i] = u_slave.mem[i];
        end

        mark = errors;
        check_value("awvalid", 64'(m_axi_awvalid), 64'd0);
        check_value("wvalid", 64'(m_axi_wvalid), 64'd0);
        check_value("busy", 64'(busy), 64'd0);
        check_value("done", 64'(done), 64'd0);
        check_value("err_count", 64'(err_count), 64'd0);
        check_value("outstanding", 64'(outstanding), 64'd0);
        report_test("after reset", errors - mark);

        mark = errors;
        issue_write(32'h0000_0120, 64'h0123_4567_89ab_cdef, 8'hf3);
        wait_idle();
        check_memory();
        check_value("outstanding", 64'(outstanding), 64'd0);
        check_value("done count", 64'(done_count), 64'(expect_done));
        report_test("single write", errors - mark);

        mark = errors;
        stall_en = 1'b1;
        for (int k = 0; k < NUM_RANDOM; k++) begin
            rnd  = random_word(12);
            addr = {17'd0, rnd[11:0], 3'b000};
            rnd  = random_word(8);
            issue_write(addr, random_word(64), rnd[7:0]);
        end
        wait_idle();
        check_memory();
        check_value("done count", 64'(done_count), 64'(expect_done));
        check_value("err_count", 64'(err_count), 64'(expect_err));
        report_test("random writes with stalls", errors - mark);

        // Even writes hit the error window, odd ones stay below it
        mark = errors;
        for (int k = 0; k < NUM_ERR; k++) begin
            rnd  = random_word(12);
            addr = {16'd0, (k % 2 == 0), rnd[11:0], 3'b000};
            issue_write(addr, random_word(64), 8'hff);
            wait_idle();
            check_value("err_count", 64'(err_count), 64'(expect_err));
        end
        check_memory();
        check_value("done count", 64'(done_count), 64'(expect_done));
        report_test("error counting", errors - mark);

        report_test("axi stability", stab_fail);
        report_test("aw and w ordering", order_fail);

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks,
                 errors + stab_fail + order_fail);
        if (errors + stab_fail + order_fail == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
source/axiwr_pkg.sv
source/wdata_fifo.sv
source/aw_hold.sv
source/axiwr_master.sv
source/wr_req_tracker.sv
source/axiwr_top.sv
tests/axi_slave_model.sv
tests/tb_axiwr_top.sv

/* Bender.yml */
package:
  name: axiwr

sources:
  - files:
      - source/axiwr_pkg.sv
      - source/wdata_fifo.sv
      - source/aw_hold.sv
      - source/axiwr_master.sv
      - source/wr_req_tracker.sv
      - source/axiwr_top.sv
  - target: test
    files:
      - tests/axi_slave_model.sv
      - tests/tb_axiwr_top.sv
